// File: source/exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// ------------------------------
// Widths
// ------------------------------
`define EXEC_XLEN      32  // Data word.
`define EXEC_REG_BITS  5   // Register index.

// ------------------------------
// Operand select codes
// ------------------------------
`define EXEC_SRC_A_RS1   2'd0
`define EXEC_SRC_A_PC    2'd1
`define EXEC_SRC_A_ZERO  2'd2  // Code 3 also yields zero.

`define EXEC_SRC_B_IMM   2'd0
`define EXEC_SRC_B_RS2   2'd1
`define EXEC_SRC_B_CSR   2'd2
`define EXEC_SRC_B_ZERO  2'd3

`endif

// File: source/exec_pkg.sv
`default_nettype none

`include "exec_settings.svh"

package exec_pkg;

    // Data and field types.
    typedef logic [`EXEC_XLEN-1:0]     word_t;
    typedef logic [`EXEC_REG_BITS-1:0] reg_idx_t;
    typedef logic [2:0]                funct3_t;
    typedef logic [1:0]                src_sel_t;

    // ALU operations. Unlisted codes give a zero result.
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_t;

endpackage

`default_nettype wire

// File: source/exec_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

interface exec_stage_if (
    input logic clock,
    input logic reset
);
    import exec_pkg::*;

    word_t    pc;
    word_t    imm;
    word_t    rs1_value;
    word_t    rs2_value;
    word_t    csr_value;
    src_sel_t src_a_sel;
    src_sel_t src_b_sel;
    alu_op_t  alu_op;
    logic     invert;   // Flip bit 0 of the ALU result.
    logic     jump;
    logic     branch;

    modport ctrl (output pc, imm, rs1_value, rs2_value, csr_value,
                  output src_a_sel, src_b_sel, alu_op, invert, jump, branch);
    modport operand (input clock, reset, pc, imm, rs1_value, rs2_value, csr_value,
                     input src_a_sel, src_b_sel);
    modport alu (input alu_op, invert);
    modport resolve (input clock, reset, pc, imm, jump, branch);

endinterface

`default_nettype wire

// File: source/exec_stage_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage_ctrl (
    input  logic              clock,
    input  logic              reset,
    input  logic              valid_in,
    output logic              ready_out,
    output logic              valid_out,
    input  logic              ready_in,
    input  exec_pkg::word_t   pc_in,
    input  exec_pkg::word_t   imm_in,
    input  exec_pkg::word_t   rs1_in,
    input  exec_pkg::word_t   rs2_in,
    input  exec_pkg::word_t   csr_in,
    input  exec_pkg::src_sel_t src_a_sel_in,
    input  exec_pkg::src_sel_t src_b_sel_in,
    input  exec_pkg::alu_op_t alu_op_in,
    input  logic              invert_in,
    input  logic              jump_in,
    input  logic              branch_in,
    input  logic              reg_wen_in,
    input  logic              mem_wen_in,
    input  logic              mem_ren_in,
    input  exec_pkg::reg_idx_t rd_in,
    input  exec_pkg::funct3_t funct3_in,
    exec_stage_if.ctrl        stage,
    output exec_pkg::reg_idx_t rd_out,
    output exec_pkg::funct3_t funct3_out,
    output logic              reg_wen_out,
    output logic              mem_wen_out,
    output logic              mem_ren_out,
    output exec_pkg::word_t   rs2_out
);
    import exec_pkg::*;

    logic transfer;

    assign ready_out = ready_in;  // Stage never stalls on its own.
    assign transfer  = valid_in && ready_out;

    // ------------------------------
    // Valid pulse
    // ------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= transfer;  // High one cycle per transfer.
        end
    end

    // ------------------------------
    // Stage register
    // ------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            stage.pc        <= '0;
            stage.imm       <= '0;
            stage.rs1_value <= '0;
            stage.rs2_value <= '0;
            stage.csr_value <= '0;
            stage.src_a_sel <= '0;
            stage.src_b_sel <= '0;
            stage.alu_op    <= ALU_ADD;
            stage.invert    <= 1'b0;
            stage.jump      <= 1'b0;
            stage.branch    <= 1'b0;
            rd_out          <= '0;
            funct3_out      <= '0;
            reg_wen_out     <= 1'b0;
            mem_wen_out     <= 1'b0;
            mem_ren_out     <= 1'b0;
        end else if (transfer) begin
            stage.pc        <= pc_in;
            stage.imm       <= imm_in;
            stage.rs1_value <= rs1_in;
            stage.rs2_value <= rs2_in;
            stage.csr_value <= csr_in;
            stage.src_a_sel <= src_a_sel_in;
            stage.src_b_sel <= src_b_sel_in;
            stage.alu_op    <= alu_op_in;
            stage.invert    <= invert_in;
            stage.jump      <= jump_in;
            stage.branch    <= branch_in;
            rd_out          <= rd_in;
            funct3_out      <= funct3_in;
            reg_wen_out     <= reg_wen_in;
            mem_wen_out     <= mem_wen_in;
            mem_ren_out     <= mem_ren_in;
        end
    end

    assign rs2_out = stage.rs2_value;  // Store data for the memory stage.

    // The datapath sees only defined operations while the result is consumed.
    a_alu_op_defined: assert property (
        @(posedge clock) disable iff (reset)
        valid_out |-> stage.alu_op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
                                           ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
                                           ALU_PASS_B}
    );

endmodule

`default_nettype wire

// File: source/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module operand_select (
    exec_stage_if.operand   stage,
    output exec_pkg::word_t operand_a,
    output exec_pkg::word_t operand_b
);

    // ------------------------------
    // Operand A
    // ------------------------------
    always_comb begin
        case (stage.src_a_sel)
            `EXEC_SRC_A_RS1:  operand_a = stage.rs1_value;
            `EXEC_SRC_A_PC:   operand_a = stage.pc;         // AUIPC and JAL.
            `EXEC_SRC_A_ZERO: operand_a = `EXEC_XLEN'(0);  // LUI and CSR moves.
            default:          operand_a = `EXEC_XLEN'(0);
        endcase
    end

    // ------------------------------
    // Operand B
    // ------------------------------
    always_comb begin
        case (stage.src_b_sel)
            `EXEC_SRC_B_IMM:  operand_b = stage.imm;
            `EXEC_SRC_B_RS2:  operand_b = stage.rs2_value;
            `EXEC_SRC_B_CSR:  operand_b = stage.csr_value;
            `EXEC_SRC_B_ZERO: operand_b = `EXEC_XLEN'(0);
            default:          operand_b = `EXEC_XLEN'(0);
        endcase
    end

    // Decode should never emit the spare A code.
    a_src_a_code_unused: assert property (
        @(posedge stage.clock) disable iff (stage.reset)
        stage.src_a_sel != 2'd3
    ) else $warning("operand A select code 3 is unused, operand A is zero");

endmodule

`default_nettype wire

// File: source/exec_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module exec_alu (
    exec_stage_if.alu       stage,
    input  exec_pkg::word_t operand_a,
    input  exec_pkg::word_t operand_b,
    output exec_pkg::word_t alu_result
);
    import exec_pkg::*;

    localparam int SHAMT_BITS = $clog2(`EXEC_XLEN);

    logic [SHAMT_BITS-1:0] shamt;
    word_t                 raw_result;

    assign shamt = operand_b[SHAMT_BITS-1:0];  // Low bits of B only.

    // ------------------------------
    // Operation select
    // ------------------------------
    always_comb begin
        case (stage.alu_op)
            ALU_ADD:    raw_result = operand_a + operand_b;
            ALU_SUB:    raw_result = operand_a - operand_b;
            ALU_SLL:    raw_result = operand_a << shamt;
            ALU_SLT:    raw_result = word_t'($signed(operand_a) < $signed(operand_b));
            ALU_SLTU:   raw_result = word_t'(operand_a < operand_b);
            ALU_XOR:    raw_result = operand_a ^ operand_b;
            ALU_SRL:    raw_result = operand_a >> shamt;
            ALU_SRA:    raw_result = word_t'($signed(operand_a) >>> shamt);
            ALU_OR:     raw_result = operand_a | operand_b;
            ALU_AND:    raw_result = operand_a & operand_b;
            ALU_PASS_B: raw_result = operand_b;
            default:    raw_result = '0;  // Undefined code.
        endcase
    end

    // Invert of bit 0 turns BLT into BGE, BLTU into BGEU and so on.
    assign alu_result = {raw_result[`EXEC_XLEN-1:1], raw_result[0] ^ stage.invert};

endmodule

`default_nettype wire

// File: source/branch_resolve.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module branch_resolve (
    exec_stage_if.resolve   stage,
    input  exec_pkg::word_t alu_result,
    output exec_pkg::word_t result,
    output exec_pkg::word_t redirect_target,
    output logic            redirect
);
    import exec_pkg::*;

    word_t link_addr;
    word_t branch_addr;

    assign link_addr   = stage.pc + `EXEC_XLEN'(4);
    assign branch_addr = stage.pc + stage.imm;  // Branch target, also the idle target.

    // ------------------------------
    // Result and redirect
    // ------------------------------
    always_comb begin
        if (stage.jump) begin
            result          = link_addr;  // Return address for the link register.
            redirect        = 1'b1;
            // JAL and JALR both add in the ALU, bit 0 is dropped.
            redirect_target = {alu_result[`EXEC_XLEN-1:1], 1'b0};
        end else begin
            result          = alu_result;
            redirect        = stage.branch && alu_result[0];
            redirect_target = branch_addr;
        end
    end

    // Decode marks an instruction as a jump or a branch, never both.
    a_jump_branch_exclusive: assert property (
        @(posedge stage.clock) disable iff (stage.reset)
        !(stage.jump && stage.branch)
    );

endmodule

`default_nettype wire

// File: source/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  logic               clock,
    input  logic               reset,
    input  logic               valid_in,
    output logic               ready_out,
    output logic               valid_out,
    input  logic               ready_in,
    input  exec_pkg::word_t    pc_in,
    input  exec_pkg::word_t    imm_in,
    input  exec_pkg::word_t    rs1_in,
    input  exec_pkg::word_t    rs2_in,
    input  exec_pkg::word_t    csr_in,
    input  exec_pkg::src_sel_t src_a_sel_in,
    input  exec_pkg::src_sel_t src_b_sel_in,
    input  exec_pkg::alu_op_t  alu_op_in,
    input  logic               invert_in,
    input  logic               jump_in,
    input  logic               branch_in,
    input  logic               reg_wen_in,
    input  logic               mem_wen_in,
    input  logic               mem_ren_in,
    input  exec_pkg::reg_idx_t rd_in,
    input  exec_pkg::funct3_t  funct3_in,
    output exec_pkg::reg_idx_t rd_out,
    output exec_pkg::funct3_t  funct3_out,
    output logic               reg_wen_out,
    output logic               mem_wen_out,
    output logic               mem_ren_out,
    output exec_pkg::word_t    rs2_out,
    output exec_pkg::word_t    result,
    output logic               redirect,
    output exec_pkg::word_t    redirect_target
);
    import exec_pkg::*;

    word_t operand_a;
    word_t operand_b;
    word_t alu_result;

    exec_stage_if u_stage (.clock(clock), .reset(reset));  // Registered fields.

    // ------------------------------
    // Stage register and handshake
    // ------------------------------
    exec_stage_ctrl u_ctrl (
        .clock, .reset, .valid_in, .ready_out, .valid_out, .ready_in,
        .pc_in, .imm_in, .rs1_in, .rs2_in, .csr_in,
        .src_a_sel_in, .src_b_sel_in, .alu_op_in,
        .invert_in, .jump_in, .branch_in,
        .reg_wen_in, .mem_wen_in, .mem_ren_in, .rd_in, .funct3_in,
        .stage(u_stage.ctrl),
        .rd_out, .funct3_out, .reg_wen_out, .mem_wen_out, .mem_ren_out, .rs2_out
    );

    // ------------------------------
    // Datapath
    // ------------------------------
    operand_select u_operand (.stage(u_stage.operand), .operand_a, .operand_b);

    exec_alu u_alu (.stage(u_stage.alu), .operand_a, .operand_b, .alu_result);

    branch_resolve u_resolve (
        .stage(u_stage.resolve), .alu_result, .result, .redirect_target, .redirect
    );

endmodule

`default_nettype wire

// File: test/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Expected result, redirect flag and target of one instruction.
function automatic void model_execute(
    input  word_t    pc,
    input  word_t    imm,
    input  word_t    rs1,
    input  word_t    rs2,
    input  word_t    csr,
    input  src_sel_t src_a,
    input  src_sel_t src_b,
    input  alu_op_t  op,
    input  logic     invert,
    input  logic     jump,
    input  logic     branch,
    output word_t    result,
    output logic     redirect,
    output word_t    target
);
    word_t a;
    word_t b;
    word_t value;

    case (src_a)
        `EXEC_SRC_A_RS1: a = rs1;
        `EXEC_SRC_A_PC:  a = pc;
        default:         a = '0;  // Zero code and the spare code.
    endcase
    case (src_b)
        `EXEC_SRC_B_IMM: b = imm;
        `EXEC_SRC_B_RS2: b = rs2;
        `EXEC_SRC_B_CSR: b = csr;
        default:         b = '0;
    endcase

    case (op)
        ALU_ADD:    value = a + b;
        ALU_SUB:    value = a - b;
        ALU_SLL:    value = a << b[4:0];
        ALU_SLT:    value = {31'd0, $signed(a) < $signed(b)};
        ALU_SLTU:   value = {31'd0, a < b};
        ALU_XOR:    value = a ^ b;
        ALU_SRL:    value = a >> b[4:0];
        ALU_SRA:    value = $signed(a) >>> b[4:0];
        ALU_OR:     value = a | b;
        ALU_AND:    value = a & b;
        ALU_PASS_B: value = b;
        default:    value = '0;
    endcase
    value[0] = value[0] ^ invert;

    if (jump) begin
        result   = pc + 32'd4;  // Link address.
        redirect = 1'b1;
        target   = value & ~32'd1;
    end else begin
        result   = value;
        redirect = branch && value[0];
        target   = pc + imm;
    end
endfunction

`endif

// File: test/exec_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module exec_unit_tb;
    import exec_pkg::*;

    `include "exec_model.svh"

    localparam logic [31:0] SEED      = 32'hb45f_1d44;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam int CLOCK_PERIOD = 8;
    localparam int RESET_CYCLES = 8;
    localparam int TRANSFERS    = 200;  // Per sweep.
    localparam int BP_CYCLES    = 400;
    localparam int TEST_CYCLES  = RESET_CYCLES + 4 * (TRANSFERS + 2) + BP_CYCLES + 30;

    logic clock, reset, valid_in, ready_out, valid_out, ready_in;
    word_t pc_in, imm_in, rs1_in, rs2_in, csr_in, rs2_out, result, redirect_target;
    src_sel_t src_a_sel_in, src_b_sel_in;
    alu_op_t alu_op_in;
    logic invert_in, jump_in, branch_in, reg_wen_in, mem_wen_in, mem_ren_in;
    logic reg_wen_out, mem_wen_out, mem_ren_out, redirect;
    reg_idx_t rd_in, rd_out;
    funct3_t funct3_in, funct3_out;

    // Expectation for the instruction now held in the stage.
    logic exp_valid, exp_redirect, exp_reg_wen, exp_mem_wen, exp_mem_ren;
    word_t exp_result, exp_target, exp_rs2;
    reg_idx_t exp_rd;
    funct3_t exp_funct3;

    logic [31:0] lfsr_state;
    int error_count, transfer_count, cycle_count, start_errors, start_transfers;

    exec_unit u_exec_unit (.*);

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] lfsr_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ LFSR_TAPS : lfsr_state >> 1;
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic scramble_fields(input bit with_flow);
        logic [1:0] flow;
        pc_in = lfsr_bits(32) & ~32'd3;  // Word aligned.
        imm_in = lfsr_bits(32);
        rs1_in = lfsr_bits(32);
        rs2_in = lfsr_bits(32);
        csr_in = lfsr_bits(32);
        src_a_sel_in = src_sel_t'(lfsr_bits(2) % 3);
        src_b_sel_in = src_sel_t'(lfsr_bits(2));
        alu_op_in = alu_op_t'(4'(lfsr_bits(4) % 11));
        invert_in = lfsr_bits(1) != 0;
        rd_in = reg_idx_t'(lfsr_bits(5));
        funct3_in = funct3_t'(lfsr_bits(3));
        reg_wen_in = lfsr_bits(1) != 0;
        mem_wen_in = lfsr_bits(1) != 0;
        mem_ren_in = lfsr_bits(1) != 0;
        flow = with_flow ? 2'(lfsr_bits(2)) : 2'd0;
        jump_in = flow == 2'd1;
        branch_in = flow == 2'd2;  // Never both.
    endtask

    task automatic send_transfer();
        logic accepted;
        valid_in = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clock);
            accepted = ready_out;
            @(posedge clock);
            #1;
        end
    endtask

    task automatic finish_test(input string name);
        valid_in = 1'b0;
        @(negedge clock);
        @(posedge clock);
        #1;
        $display("test %-14s done: %0d transfers, %0d errors", name,
                 transfer_count - start_transfers, error_count - start_errors);
        start_errors = error_count;
        start_transfers = transfer_count;
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic after_reset();
        @(negedge clock);
        if (valid_out !== 1'b0 || redirect !== 1'b0)
            report_error("valid_out or redirect high after reset");
        for (int n = 0; n < 6; n++) begin
            @(posedge clock);
            #1;
            ready_in = lfsr_bits(1) != 0;
            @(negedge clock);
            if (ready_out !== ready_in)
                report_error($sformatf("ready_out %b, ready_in %b", ready_out, ready_in));
        end
        @(posedge clock);
        #1;
        ready_in = 1'b1;
        finish_test("reset");
    endtask

    // Kind 0 ALU ops, 1 branches, 2 jumps, 3 pass-through with mixed flow.
    task automatic transfer_sweep(input int kind, input string name);
        for (int n = 0; n < TRANSFERS; n++) begin
            scramble_fields(kind == 3);
            if (kind == 1) begin
                case (lfsr_bits(2))
                    32'd0:   alu_op_in = ALU_SUB;
                    32'd1:   alu_op_in = ALU_SLT;
                    32'd2:   alu_op_in = ALU_SLTU;
                    default: alu_op_in = ALU_XOR;
                endcase
                src_a_sel_in = `EXEC_SRC_A_RS1;
                src_b_sel_in = `EXEC_SRC_B_RS2;
                branch_in = 1'b1;
                if (lfsr_bits(1) != 0)
                    rs2_in = rs1_in;  // Equal operands now and then.
            end else if (kind == 2) begin
                alu_op_in = ALU_ADD;
                invert_in = 1'b0;
                src_a_sel_in = (lfsr_bits(1) != 0) ? `EXEC_SRC_A_PC : `EXEC_SRC_A_RS1;
                src_b_sel_in = `EXEC_SRC_B_IMM;
                jump_in = 1'b1;
            end
            send_transfer();
        end
        finish_test(name);
    endtask

    task automatic back_pressure_mix();
        for (int n = 0; n < BP_CYCLES; n++) begin
            scramble_fields(1'b1);
            valid_in = lfsr_bits(1) != 0;
            ready_in = lfsr_bits(1) != 0;
            @(posedge clock);
            #1;
        end
        ready_in = 1'b1;
        finish_test("back-pressure");
    endtask

    // ------------------------------
    // Output monitor
    // ------------------------------
    always @(negedge clock) begin
        if (reset) begin
            exp_valid = 1'b0;
            model_execute('0, '0, '0, '0, '0, '0, '0, ALU_ADD, 1'b0, 1'b0, 1'b0,
                          exp_result, exp_redirect, exp_target);
            {exp_rd, exp_funct3, exp_reg_wen, exp_mem_wen, exp_mem_ren} = '0;
            exp_rs2 = '0;
        end else begin
            cycle_count++;
            if (ready_out !== ready_in)
                report_error($sformatf("ready_out %b, ready_in %b", ready_out, ready_in));
            if (valid_out !== exp_valid)
                report_error($sformatf("valid_out %b, expected %b", valid_out, exp_valid));
            if (result !== exp_result)
                report_error($sformatf("result %h, expected %h", result, exp_result));
            if (redirect !== exp_redirect)
                report_error($sformatf("redirect %b, expected %b", redirect, exp_redirect));
            if (redirect_target !== exp_target)
                report_error($sformatf("target %h, expected %h", redirect_target, exp_target));
            if (rd_out !== exp_rd || funct3_out !== exp_funct3)
                report_error($sformatf("rd/funct3 %0d/%0d, expected %0d/%0d",
                                       rd_out, funct3_out, exp_rd, exp_funct3));
            if ({reg_wen_out, mem_wen_out, mem_ren_out} !== {exp_reg_wen, exp_mem_wen, exp_mem_ren})
                report_error("write/read enables differ from the accepted inputs");
            if (rs2_out !== exp_rs2)
                report_error($sformatf("rs2_out %h, expected %h", rs2_out, exp_rs2));
            exp_valid = valid_in && ready_in;  // Transfer at the coming edge.
            if (exp_valid) begin
                transfer_count++;
                model_execute(pc_in, imm_in, rs1_in, rs2_in, csr_in, src_a_sel_in,
                              src_b_sel_in, alu_op_in, invert_in, jump_in, branch_in,
                              exp_result, exp_redirect, exp_target);
                exp_rd = rd_in;
                exp_funct3 = funct3_in;
                exp_reg_wen = reg_wen_in;
                exp_mem_wen = mem_wen_in;
                exp_mem_ren = mem_ren_in;
                exp_rs2 = rs2_in;
            end
        end
    end

    initial begin
        #(CLOCK_PERIOD * (TEST_CYCLES + 100));
        $display("Timeout: the tests did not finish within %0d cycles", TEST_CYCLES + 100);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        lfsr_state = SEED;
        {error_count, transfer_count, cycle_count, start_errors, start_transfers} = '0;
        reset = 1'b1;
        {valid_in, ready_in, invert_in, jump_in, branch_in} = '0;
        {reg_wen_in, mem_wen_in, mem_ren_in} = '0;
        {pc_in, imm_in, rs1_in, rs2_in, csr_in} = '0;
        src_a_sel_in = '0;
        src_b_sel_in = '0;
        alu_op_in = ALU_ADD;
        rd_in = '0;
        funct3_in = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;

        after_reset();
        transfer_sweep(0, "alu");
        transfer_sweep(1, "branch");
        transfer_sweep(2, "jump");
        transfer_sweep(3, "pass-through");
        back_pressure_mix();

        $display("summary: %0d cycles checked, %0d transfers, %0d errors",
                 cycle_count, transfer_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: exec_unit.f
+incdir+source
+incdir+test
source/exec_pkg.sv
source/exec_stage_if.sv
source/exec_stage_ctrl.sv
source/operand_select.sv
source/exec_alu.sv
source/branch_resolve.sv
source/exec_unit.sv
test/exec_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the execute-stage testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module exec_unit_tb \
    -f exec_unit.f \
    -o exec_unit_sim

output=$(./obj_dir/exec_unit_sim)
echo "$output"

if echo "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1
